// ==== rffe_settings.svh ====
// one 8-slot frame buffer and one data byte per frame; only register, read and reg-0 commands
`ifndef RFFE_SETTINGS_SVH
`define RFFE_SETTINGS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////
`define RFFE_DIV_NBIT       8   // bus clock period in clk cycles
`define RFFE_BUF_ADDR_NBIT  3
`define RFFE_DATA_NBIT      8
`define RFFE_SA_NBIT        4   // slave address bits on the bus

// divide values below this are clamped
`define RFFE_DIV_MIN        2

//////////////////////////////////////////////////
// frame buffer slots
//////////////////////////////////////////////////
`define RFFE_SA_SLOT        3'd0
`define RFFE_CMD_SLOT       3'd1
`define RFFE_ADDR_SLOT      3'd2
`define RFFE_DATA_SLOT      3'd3  // write byte, or the captured read byte

//////////////////////////////////////////////////
// command decode
//////////////////////////////////////////////////
`define RFFE_CMD_REG_MASK   8'he0 // cmd[7:5]
`define RFFE_CMD_ZERO_MASK  8'h80 // cmd[7]
`define RFFE_CMD_WR_PAT     8'h40 // 010x_xxxx
`define RFFE_CMD_RD_PAT     8'h60 // 011x_xxxx
`define RFFE_CMD_WRZERO_PAT 8'h80 // 1xxx_xxxx

`endif

// ==== rffe_pkg.sv ====
// shared types only; widths come from rffe_settings.svh and must not be changed independently
`include "rffe_settings.svh"

`default_nettype none

package rffe_pkg;

   //////////////////////////////////////////////////
   // vectors
   //////////////////////////////////////////////////
   typedef logic [`RFFE_DIV_NBIT-1:0]      div_t;      // bus clock period, clk cycles
   typedef logic [`RFFE_BUF_ADDR_NBIT-1:0] buf_addr_t;
   typedef logic [`RFFE_DATA_NBIT-1:0]     bus_byte_t;

   // sequencer states, stepped on bit ticks
   typedef enum logic [2:0] {
      st_idle,
      st_ssc,     // sequence start, sclk held low
      st_sa,
      st_cmd,     // command byte plus parity
      st_data,    // write byte plus parity
      st_park,
      st_rd_data, // eight slave bits plus slave parity
      st_done
   } seq_state_e;

   //////////////////////////////////////////////////
   // structs
   //////////////////////////////////////////////////
   // sequencer side of the frame buffer
   typedef struct packed {
      logic      wr;
      buf_addr_t addr;
      bus_byte_t wdata;
   } buf_req_t;

   // bus drive before the phase gating in the top level
   typedef struct packed {
      logic sclk_en;
      logic sdata;
      logic sdata_en;
      logic park;     // park bit, sdata_en only in the first half
   } bus_drive_t;

endpackage

`default_nettype wire

// ==== rffe_clk_div.sv ====
// div below RFFE_DIV_MIN is clamped; a set restarts the bit timing, first tick div cycles later
`include "rffe_settings.svh"

`default_nettype none

module rffe_clk_div (
   input  logic           clk,
   input  logic           i_arst_n,
   input  logic           i_set,
   input  rffe_pkg::div_t i_div,
   output logic           o_tick,
   output logic           o_first_half
);

   import rffe_pkg::*;

   div_t div_q;     // programmed period
   div_t cnt_q;     // cycles left in this bit
   div_t div_clamp;
   div_t high_len;  // sclk high time

   assign div_clamp = (i_div < div_t'(`RFFE_DIV_MIN)) ? div_t'(`RFFE_DIV_MIN) : i_div;

   //////////////////////////////////////////////////
   // period counter
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         div_q <= div_t'(`RFFE_DIV_MIN);
         cnt_q <= div_t'(`RFFE_DIV_MIN - 1);
      end else if (i_set) begin
         div_q <= div_clamp;
         cnt_q <= div_clamp - 1'b1;
      end else if (cnt_q == '0) begin
         cnt_q <= div_q - 1'b1; // next bit
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // tick marks the edge where a new bit starts
   assign o_tick = (cnt_q == '0);

   // high for floor(div/2) cycles right after the tick
   assign high_len     = div_q >> 1;
   assign o_first_half = (cnt_q >= (div_q - high_len));

endmodule

`default_nettype wire

// ==== rffe_frame_buf.sv ====
// host writes are dropped while busy; both read ports return data one clk cycle after the address
`include "rffe_settings.svh"

`default_nettype none

module rffe_frame_buf (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_busy,
   input  logic                i_host_wr,
   input  rffe_pkg::buf_addr_t i_host_addr,
   input  rffe_pkg::bus_byte_t i_host_wdata,
   output rffe_pkg::bus_byte_t o_host_rdata,
   input  rffe_pkg::buf_req_t  i_seq_req,
   output rffe_pkg::bus_byte_t o_seq_rdata
);

   import rffe_pkg::*;

   localparam int unsigned DEPTH = 2 ** `RFFE_BUF_ADDR_NBIT;

   bus_byte_t mem [DEPTH];
   logic      host_wr_ok;

   assign host_wr_ok = i_host_wr & ~i_busy; // frame contents frozen during a transfer

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (i_seq_req.wr) begin
         mem[i_seq_req.addr] <= i_seq_req.wdata; // captured read byte
      end else if (host_wr_ok) begin
         mem[i_host_addr] <= i_host_wdata;
      end
   end

   //////////////////////////////////////////////////
   // registered reads
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_host_rdata <= '0;
         o_seq_rdata  <= '0;
      end else begin
         o_host_rdata <= mem[i_host_addr];
         o_seq_rdata  <= mem[i_seq_req.addr];
      end
   end

endmodule

`default_nettype wire

// ==== rffe_frame_seq.sv ====
// needs at least 2 clk cycles per tick for buffer reads; slave read parity is not checked
`include "rffe_settings.svh"

`default_nettype none

module rffe_frame_seq (
   input  logic                 clk,
   input  logic                 i_arst_n,
   input  logic                 i_tick,
   input  logic                 i_start,
   input  logic                 i_sdata,
   input  rffe_pkg::bus_byte_t  i_buf_rdata,
   output rffe_pkg::buf_req_t   o_buf_req,
   output rffe_pkg::bus_drive_t o_bus,
   output logic                 o_busy,
   output logic                 o_done
);

   import rffe_pkg::*;

   localparam int         MSB       = `RFFE_DATA_NBIT - 1;
   localparam logic [3:0] BYTE_BITS = 4'(`RFFE_DATA_NBIT);
   localparam logic [3:0] SA_FIRST  = 4'(`RFFE_SA_NBIT - 1);

   seq_state_e state_q;
   bus_byte_t  shift_q;      // msb goes out first
   bus_byte_t  cmd_q;
   logic [3:0] cnt_q;        // bits left, 0 is the parity bit
   logic       par_q;        // xor of the bits sent so far
   logic       start_pend_q;
   logic       turn_q;       // this park bit hands the bus to the slave
   logic       is_wr_q;
   logic       is_rd_q;
   logic       is_zero_q;
   buf_req_t   req_q;
   logic       go;
   logic       dec_wr;
   logic       dec_rd;
   logic       dec_zero;

   // command class of the byte coming out of the buffer
   assign dec_zero = (i_buf_rdata & `RFFE_CMD_ZERO_MASK) == `RFFE_CMD_WRZERO_PAT;
   assign dec_wr   = (i_buf_rdata & `RFFE_CMD_REG_MASK) == `RFFE_CMD_WR_PAT;
   assign dec_rd   = (i_buf_rdata & `RFFE_CMD_REG_MASK) == `RFFE_CMD_RD_PAT;

   //////////////////////////////////////////////////
   // start latch
   //////////////////////////////////////////////////
   assign go = i_tick & (start_pend_q | i_start) & (state_q == st_idle);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         start_pend_q <= 1'b0;
      end else if (state_q != st_idle || go) begin
         start_pend_q <= 1'b0; // a start during a frame is dropped
      end else if (i_start) begin
         start_pend_q <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // frame FSM
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q   <= st_idle;
         shift_q   <= '0;
         cmd_q     <= '0;
         cnt_q     <= '0;
         par_q     <= 1'b0;
         turn_q    <= 1'b0;
         is_wr_q   <= 1'b0;
         is_rd_q   <= 1'b0;
         is_zero_q <= 1'b0;
         req_q     <= '{wr: 1'b0, addr: `RFFE_SA_SLOT, wdata: '0};
      end else begin
         req_q.wr <= 1'b0; // write strobe is one cycle
         case (state_q)
            st_idle: begin
               req_q.addr <= `RFFE_SA_SLOT; // slave address ready before the ssc ends
               if (go) begin
                  state_q <= st_ssc;
                  shift_q <= bus_byte_t'(1) << MSB; // ssc is 1 then 0
                  cnt_q   <= 4'd1;
               end
            end
            st_ssc: if (i_tick) begin
               shift_q <= shift_q << 1;
               cnt_q   <= cnt_q - 1'b1;
               if (cnt_q == '0) begin
                  state_q    <= st_sa;
                  shift_q    <= {i_buf_rdata[`RFFE_SA_NBIT-1:0],
                                 {(`RFFE_DATA_NBIT-`RFFE_SA_NBIT){1'b0}}};
                  cnt_q      <= SA_FIRST;
                  par_q      <= 1'b0;
                  req_q.addr <= `RFFE_CMD_SLOT;
               end
            end
            st_sa: if (i_tick) begin
               shift_q <= shift_q << 1;
               par_q   <= par_q ^ shift_q[MSB];
               cnt_q   <= cnt_q - 1'b1;
               if (cnt_q == SA_FIRST) begin
                  // command byte is in, fetch the slot that fills its low bits
                  cmd_q      <= i_buf_rdata;
                  is_wr_q    <= dec_wr;
                  is_rd_q    <= dec_rd;
                  is_zero_q  <= dec_zero;
                  req_q.addr <= dec_zero ? `RFFE_DATA_SLOT : `RFFE_ADDR_SLOT;
               end
               if (cnt_q == '0) begin
                  state_q    <= st_cmd;
                  cnt_q      <= BYTE_BITS;
                  req_q.addr <= `RFFE_DATA_SLOT;
                  if (is_zero_q) begin
                     shift_q <= {cmd_q[7], i_buf_rdata[6:0]};
                  end else if (is_wr_q || is_rd_q) begin
                     shift_q <= {cmd_q[7:5], i_buf_rdata[4:0]};
                  end else begin
                     shift_q <= cmd_q; // sent as is, then aborted
                  end
               end
            end
            st_cmd, st_data: if (i_tick) begin
               if (cnt_q != '0) begin
                  shift_q <= shift_q << 1;
                  par_q   <= par_q ^ shift_q[MSB];
                  cnt_q   <= cnt_q - 1'b1;
               end else if (state_q == st_cmd && is_wr_q) begin
                  state_q <= st_data;
                  shift_q <= i_buf_rdata;
                  cnt_q   <= BYTE_BITS;
                  par_q   <= 1'b0; // data frame has its own parity
               end else if (state_q == st_data || is_rd_q || is_zero_q) begin
                  state_q <= st_park;
                  turn_q  <= (state_q == st_cmd) & is_rd_q;
               end else begin
                  state_q <= st_idle; // unknown command, no done
               end
            end
            st_park: if (i_tick) begin
               if (turn_q) begin
                  state_q <= st_rd_data;
                  shift_q <= '0;
                  cnt_q   <= BYTE_BITS;
                  turn_q  <= 1'b0;
               end else begin
                  state_q <= st_done;
               end
            end
            st_rd_data: if (i_tick) begin
               // bit driven after its falling edge, sampled at the tick ending it
               if (cnt_q != '0) begin
                  shift_q <= {shift_q[MSB-1:0], i_sdata};
                  cnt_q   <= cnt_q - 1'b1;
               end else begin
                  state_q     <= st_park;
                  req_q.wr    <= 1'b1;
                  req_q.addr  <= `RFFE_DATA_SLOT;
                  req_q.wdata <= shift_q;
               end
            end
            st_done: state_q <= st_idle; // one clk cycle only
            default: state_q <= st_idle;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // bus drive
   //////////////////////////////////////////////////
   always_comb begin
      o_bus = '0;
      case (state_q)
         st_ssc: begin
            o_bus.sdata    = shift_q[MSB];
            o_bus.sdata_en = 1'b1;
         end
         st_sa: begin
            o_bus.sclk_en  = 1'b1;
            o_bus.sdata    = shift_q[MSB];
            o_bus.sdata_en = 1'b1;
         end
         st_cmd, st_data: begin
            o_bus.sclk_en  = 1'b1;
            o_bus.sdata    = (cnt_q == '0) ? ~par_q : shift_q[MSB]; // odd parity
            o_bus.sdata_en = 1'b1;
         end
         st_park: begin
            o_bus.sclk_en  = 1'b1;
            o_bus.sdata_en = 1'b1;
            o_bus.park     = 1'b1;
         end
         st_rd_data: o_bus.sclk_en = 1'b1; // slave owns sdata
         default: ;
      endcase
   end

   assign o_busy    = (state_q != st_idle);
   assign o_done    = (state_q == st_done);
   assign o_buf_req = req_q;

endmodule

`default_nettype wire

// ==== rffe_master.sv ====
// one clock domain; set the divider before start, a start while busy is ignored
`default_nettype none

module rffe_master (
   input  logic                clk,
   input  logic                i_arst_n,
   // divider setting
   input  logic                i_set,
   input  rffe_pkg::div_t      i_div,
   // control
   input  logic                i_start,
   output logic                o_done,
   output logic                o_busy,
   // host side of the frame buffer
   input  logic                i_buf_wr,
   input  rffe_pkg::buf_addr_t i_buf_addr,
   input  rffe_pkg::bus_byte_t i_buf_wdata,
   output rffe_pkg::bus_byte_t o_buf_rdata,
   // RFFE bus
   output logic                o_sclk,
   output logic                o_sdata,
   output logic                o_sdata_en,
   input  logic                i_sdata
);

   import rffe_pkg::*;

   logic       tick;
   logic       first_half;
   buf_req_t   seq_req;
   bus_byte_t  seq_rdata;
   bus_drive_t bus_drv;

   //////////////////////////////////////////////////
   // blocks
   //////////////////////////////////////////////////
   rffe_clk_div u_clk_div (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_set        (i_set),
      .i_div        (i_div),
      .o_tick       (tick),
      .o_first_half (first_half)
   );

   rffe_frame_buf u_frame_buf (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_busy       (o_busy),
      .i_host_wr    (i_buf_wr),
      .i_host_addr  (i_buf_addr),
      .i_host_wdata (i_buf_wdata),
      .o_host_rdata (o_buf_rdata),
      .i_seq_req    (seq_req),
      .o_seq_rdata  (seq_rdata)
   );

   rffe_frame_seq u_frame_seq (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_tick       (tick),
      .i_start      (i_start),
      .i_sdata      (i_sdata),
      .i_buf_rdata  (seq_rdata),
      .o_buf_req    (seq_req),
      .o_bus        (bus_drv),
      .o_busy       (o_busy),
      .o_done       (o_done)
   );

   // bus pins
   assign o_sclk     = bus_drv.sclk_en & first_half;
   assign o_sdata    = bus_drv.sdata;
   assign o_sdata_en = bus_drv.sdata_en & (~bus_drv.park | first_half); // park releases mid-bit

endmodule

`default_nettype wire

// ==== rffe_props.sv ====
// sampled on clk and idle during reset; each failure also adds to fail_cnt
`default_nettype none

module rffe_props (
   input logic clk,
   input logic i_arst_n,
   input logic i_busy,
   input logic i_done,
   input logic i_sclk,
   input logic i_sdata_en
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0; // failures so far

   //////////////////////////////////////////////////
   // quiet bus between transactions
   //////////////////////////////////////////////////
   a_sclk_idle: assert property (@(posedge clk) disable iff (!i_arst_n) !i_busy |-> !i_sclk)
      else begin
         $error("sclk was high while the master was idle");
         fail_cnt++;
      end

   a_sdata_en_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
      !i_busy |-> !i_sdata_en)
      else begin
         $error("sdata was driven while the master was idle");
         fail_cnt++;
      end

   //////////////////////////////////////////////////
   // done pulse
   //////////////////////////////////////////////////
   a_done_one_cycle: assert property (@(posedge clk) disable iff (!i_arst_n) i_done |=> !i_done)
      else begin
         $error("done stayed high for more than one cycle");
         fail_cnt++;
      end

   a_done_in_busy: assert property (@(posedge clk) disable iff (!i_arst_n) i_done |-> i_busy)
      else begin
         $error("done pulsed outside a transaction");
         fail_cnt++;
      end

endmodule

bind rffe_master rffe_props u_props (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .i_busy     (o_busy),
   .i_done     (o_done),
   .i_sclk     (o_sclk),
   .i_sdata_en (o_sdata_en)
);

`default_nettype wire

// ==== rffe_tb.sv ====
// one transaction at a time; the slave model assumes sclk is high for floor(div/2) clk cycles
`include "rffe_settings.svh"

`default_nettype none

module rffe_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import rffe_pkg::*;

   localparam int RST_CYCLES = 4;
   localparam int N_RAND     = 4;
   localparam int TICKS_ROW  = 40; // generous bound on ticks per row

   typedef struct packed {
      div_t                     div;
      logic [`RFFE_SA_NBIT-1:0] sa;
      bus_byte_t                cmd;
      bus_byte_t                addr;
      bus_byte_t                data;
      bus_byte_t                rd;   // byte the slave returns on a read
   } row_t;

   logic        clk = 1'b0;
   logic        i_arst_n;
   logic        i_set;
   div_t        i_div;
   logic        i_start;
   logic        o_done;
   logic        o_busy;
   logic        i_buf_wr;
   buf_addr_t   i_buf_addr;
   bus_byte_t   i_buf_wdata;
   bus_byte_t   o_buf_rdata;
   logic        o_sclk;
   logic        o_sdata;
   logic        o_sdata_en;
   logic        i_sdata;

   row_t        rows[$];
   string       names[$];
   row_t        cur = '0;        // row on the bus
   string       cur_name = "reset";
   int          eff_div = `RFFE_DIV_MIN;
   logic [31:0] lfsr_q = 32'hb410;
   int unsigned cycles = 0;
   int unsigned limit = 0;

   logic [31:0] rec_bits = '0;   // master bits seen by the slave
   int          rec_len = 0;
   int          done_cnt = 0;
   int          fall_cnt = 0;
   int          rise_gap = -1;
   logic        sclk_prev = 1'b0;
   int          hi_run = 0;
   int          s_fall = 0;

   rffe_master DUT (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_set       (i_set),
      .i_div       (i_div),
      .i_start     (i_start),
      .o_done      (o_done),
      .o_busy      (o_busy),
      .i_buf_wr    (i_buf_wr),
      .i_buf_addr  (i_buf_addr),
      .i_buf_wdata (i_buf_wdata),
      .o_buf_rdata (o_buf_rdata),
      .o_sclk      (o_sclk),
      .o_sdata     (o_sdata),
      .o_sdata_en  (o_sdata_en),
      .i_sdata     (i_sdata)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("error %s: expected 0x%0h, actual 0x%0h", what, exp, act);
         $display("Regression failed");
         $fatal(1, "mismatch in %s", what);
      end
   endtask

   function automatic logic next_rand_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // x^32+x^22+x^2+x+1
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], next_rand_bit()};
      end
      return v;
   endfunction

   function automatic int clamp_div(input div_t d);
      return (int'(d) < `RFFE_DIV_MIN) ? `RFFE_DIV_MIN : int'(d);
   endfunction

   function automatic logic is_read(input row_t r);
      return (r.cmd & `RFFE_CMD_REG_MASK) == `RFFE_CMD_RD_PAT;
   endfunction

   // bits the slave should see on falling edges, oldest in the msb end
   function automatic logic [31:0] expected_stream(input row_t r, output int len);
      bus_byte_t   c;
      logic [31:0] s;
      if ((r.cmd & `RFFE_CMD_ZERO_MASK) == `RFFE_CMD_WRZERO_PAT) begin
         c = {1'b1, r.data[6:0]};
      end else begin
         c = {r.cmd[7:5], r.addr[4:0]};
      end
      s   = 32'({r.sa, c, ~^{r.sa, c}}); // odd parity over sa and command
      len = 13;
      if ((r.cmd & `RFFE_CMD_REG_MASK) == `RFFE_CMD_WR_PAT) begin
         s   = {s[22:0], r.data, ~^r.data};
         len = 22;
      end
      return s;
   endfunction

   task automatic add_row(input string n, input div_t d, input logic [3:0] sa,
                          input bus_byte_t cmd, input bus_byte_t addr,
                          input bus_byte_t data, input bus_byte_t rd);
      names.push_back(n);
      rows.push_back('{div: d, sa: sa, cmd: cmd, addr: addr, data: data, rd: rd});
   endtask

   task automatic add_random_rows();
      row_t r;
      int   kind;
      for (int i = 0; i < N_RAND; i++) begin
         kind   = int'(rand_bits(2)) % 3;
         r.div  = div_t'(rand_bits(3)) + div_t'(2);
         r.sa   = 4'(rand_bits(4));
         r.addr = bus_byte_t'(rand_bits(8));
         r.data = bus_byte_t'(rand_bits(8));
         r.rd   = bus_byte_t'(rand_bits(8));
         case (kind)
            0:       r.cmd = `RFFE_CMD_WR_PAT | bus_byte_t'(rand_bits(5));
            1:       r.cmd = `RFFE_CMD_RD_PAT | bus_byte_t'(rand_bits(5));
            default: r.cmd = `RFFE_CMD_WRZERO_PAT | bus_byte_t'(rand_bits(7));
         endcase
         names.push_back($sformatf("rand%0d", i));
         rows.push_back(r);
      end
   endtask

   task automatic write_slot(input buf_addr_t a, input bus_byte_t d);
      @(posedge clk);
      i_buf_wr    <= 1'b1;
      i_buf_addr  <= a;
      i_buf_wdata <= d;
      @(posedge clk);
      i_buf_wr    <= 1'b0;
   endtask

   task automatic read_slot(input buf_addr_t a, output bus_byte_t v);
      @(posedge clk);
      i_buf_addr <= a;
      @(posedge clk);
      @(negedge clk); // registered read has settled
      v = o_buf_rdata;
   endtask

   task automatic run_row(input string name, input row_t r);
      logic [31:0] exp_bits;
      int          exp_len;
      bus_byte_t   got;
      cur      = r;
      cur_name = name;
      eff_div  = clamp_div(r.div);
      @(posedge clk);
      i_set <= 1'b1;
      i_div <= r.div;
      @(posedge clk);
      i_set <= 1'b0;
      write_slot(`RFFE_SA_SLOT, bus_byte_t'(r.sa));
      write_slot(`RFFE_CMD_SLOT, r.cmd);
      write_slot(`RFFE_ADDR_SLOT, r.addr);
      write_slot(`RFFE_DATA_SLOT, r.data);
      rec_bits = '0;
      rec_len  = 0;
      done_cnt = 0;
      @(posedge clk);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
      while (!o_busy) @(posedge clk);
      write_slot(`RFFE_DATA_SLOT, ~r.data); // must be dropped
      do @(posedge clk); while (!o_done);
      exp_bits = expected_stream(r, exp_len);
      read_slot(`RFFE_DATA_SLOT, got);
      check_value({name, " stream length"}, exp_len, rec_len);
      check_value({name, " stream"}, exp_bits, rec_bits);
      check_value({name, " done pulses"}, 1, done_cnt);
      check_value({name, " data slot"}, is_read(r) ? r.rd : r.data, got);
   endtask

   //////////////////////////////////////////////////
   // bus monitor and slave
   //////////////////////////////////////////////////
   always @(negedge clk) begin
      check_value("assertion failures", 0, DUT.u_props.fail_cnt);
      if (o_done) done_cnt++;
      if (!o_busy) begin
         fall_cnt = 0;
         rise_gap = -1;
      end else begin
         if (rise_gap >= 0) rise_gap++;
         if (o_sclk && !sclk_prev) begin
            if (rise_gap > 0) check_value({cur_name, " sclk period"}, eff_div, rise_gap);
            rise_gap = 0;
         end
         if (!o_sclk && sclk_prev) begin
            fall_cnt++;
            if (o_sdata_en) begin
               rec_bits = {rec_bits[30:0], o_sdata};
               rec_len++;
            end
         end
         // turnaround park through slave parity
         if (is_read(cur) && fall_cnt >= 14 && fall_cnt <= 22) begin
            check_value({cur_name, " sdata_en in read"}, 0, o_sdata_en);
         end
      end
      sclk_prev = o_sclk;
   end

   // slave changes i_sdata at each sclk fall
   always @(posedge clk) begin
      if (!o_busy) begin
         hi_run = 0;
         s_fall = 0;
      end else if (o_sclk) begin
         hi_run++;
         if (hi_run == eff_div / 2) begin
            hi_run = 0;
            s_fall++;
            if (is_read(cur) && s_fall >= 15 && s_fall <= 22) begin
               i_sdata <= cur.rd[22 - s_fall]; // msb first
            end else if (is_read(cur) && s_fall == 23) begin
               i_sdata <= ~^cur.rd;
            end else begin
               i_sdata <= 1'b0;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles > limit) begin
         $display("timeout: no done from the DUT after %0d cycles", cycles);
         $display("Regression failed");
         $fatal(1, "simulation timed out");
      end
   end

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      i_arst_n    = 1'b0;
      i_set       = 1'b0;
      i_div       = '0;
      i_start     = 1'b0;
      i_buf_wr    = 1'b0;
      i_buf_addr  = '0;
      i_buf_wdata = '0;
      i_sdata     = 1'b0;
      //       name        div    sa     cmd    addr   data   rd
      add_row("wr_div4",  8'd4, 4'h5, 8'h5f, 8'h0a, 8'ha5, 8'h00);
      add_row("rd_div3",  8'd3, 4'h9, 8'h60, 8'h13, 8'h77, 8'h3c);
      add_row("wr0_div6", 8'd6, 4'hc, 8'h80, 8'h00, 8'hab, 8'h00);
      add_row("wr_div0",  8'd0, 4'h3, 8'h40, 8'h1f, 8'h01, 8'h00);
      add_row("rd_div1",  8'd1, 4'hf, 8'h7e, 8'h05, 8'h00, 8'hc9);
      add_row("wr0_div2", 8'd2, 4'h0, 8'hff, 8'h00, 8'h7f, 8'h00);
      add_random_rows();
      limit = RST_CYCLES + 1;
      foreach (rows[i]) begin
         limit += TICKS_ROW * clamp_div(rows[i].div);
      end
      repeat (RST_CYCLES) @(posedge clk);
      i_arst_n <= 1'b1;
      @(negedge clk);
      check_value("reset outputs", 0, {o_busy, o_done, o_sclk, o_sdata_en});
      foreach (rows[i]) begin
         run_row(names[i], rows[i]);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
rffe_pkg.sv
rffe_clk_div.sv
rffe_frame_buf.sv
rffe_frame_seq.sv
rffe_master.sv
rffe_props.sv
rffe_tb.sv
